// File: logic/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// bus widths
`define DC_ADDR_W   32
`define DC_DATA_W   32

// cache geometry
`define DC_WAYS     4
`define DC_SETS     8
`define DC_WORDS    8      // words per line

// address split
`define DC_INDEX_W  3
`define DC_OFFSET_W 5      // byte offset inside a line

// remaining upper address bits form the tag
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

// File: logic/cache_pkg.sv
`include "dcache_macros.svh"

package cache_pkg;

    localparam int WAY_W = $clog2(`DC_WAYS);

    // processor request, wen all zero is a load
    typedef struct packed {
        logic [`DC_ADDR_W-1:0]   addr;
        logic [`DC_DATA_W/8-1:0] wen;
        logic [`DC_DATA_W-1:0]   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`DC_DATA_W-1:0] rdata;
    } cpu_resp_t;

    // result of the tag compare for the held request
    typedef struct packed {
        logic                 hit;
        logic [WAY_W-1:0]     hit_way;
        logic [WAY_W-1:0]     victim_way;
        logic                 victim_dirty;
        logic [`DC_TAG_W-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_refill,
        st_respond
    } ctrl_state_e;

endpackage

// File: logic/bus_pkg.sv
`include "dcache_macros.svh"

package bus_pkg;

    // shared by the read and write address channels
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [7:0]            len;   // beats minus one
    } burst_addr_t;

    // one beat on r or w
    typedef struct packed {
        logic [`DC_DATA_W-1:0] data;
        logic                  last;
    } burst_data_t;

    // what the controller asks of the burst port
    typedef enum logic [1:0] {
        op_none,
        op_write_line,
        op_read_line
    } bus_op_e;

endpackage

// File: logic/tag_directory.sv
`include "dcache_macros.svh"

module tag_directory
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  cpu_req_t req,
    input  logic     fill_en,
    input  logic     touch_en,
    input  logic     dirty_set,
    input  logic     dirty_clear,
    output cpu_req_t cur_req,
    output lookup_t  lookup
);

    logic [`DC_TAG_W-1:0] tag_arr   [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0]  valid_arr [`DC_WAYS];
    logic [`DC_SETS-1:0]  dirty_arr [`DC_WAYS];
    logic [2:0]           lru       [`DC_SETS];   // tree bits per set

    logic [`DC_INDEX_W-1:0] idx;
    logic [`DC_TAG_W-1:0]   req_tag;
    logic [2:0]             set_lru;
    logic [WAY_W-1:0]       victim;
    logic [WAY_W-1:0]       upd_way;

    assign idx     = cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_tag = cur_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign set_lru = lru[idx];

    // bit 0 picks the half, bit 1 or 2 the way inside it
    assign victim = {set_lru[0], set_lru[0] ? set_lru[2] : set_lru[1]};

    always_ff @(posedge clk) begin
        if (req_valid) begin
            cur_req <= req;
        end
    end

    always_comb begin
        lookup              = '0;
        lookup.victim_way   = victim;
        lookup.victim_dirty = valid_arr[victim][idx] & dirty_arr[victim][idx];
        lookup.victim_tag   = tag_arr[victim][idx];
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (valid_arr[w][idx] && tag_arr[w][idx] == req_tag) begin
                lookup.hit     = 1'b1;
                lookup.hit_way = WAY_W'(w);
            end
        end
    end

    // a fill acts on the victim, everything else on the hit way
    assign upd_way = fill_en ? victim : lookup.hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
                for (int s = 0; s < `DC_SETS; s++) begin
                    tag_arr[w][s] <= '0;
                end
            end
            for (int s = 0; s < `DC_SETS; s++) begin
                lru[s] <= '0;
            end
        end else begin
            if (fill_en) begin
                tag_arr[victim][idx]   <= req_tag;
                valid_arr[victim][idx] <= 1'b1;
            end
            if (fill_en || dirty_set || dirty_clear) begin
                dirty_arr[upd_way][idx] <= dirty_set;   // fill alone leaves it clean
            end
            if (fill_en || touch_en) begin
                lru[idx][0] <= ~upd_way[1];
                if (upd_way[1]) begin
                    lru[idx][2] <= ~upd_way[0];
                end else begin
                    lru[idx][1] <= ~upd_way[0];
                end
            end
        end
    end

endmodule

// File: logic/miss_controller.sv
`include "dcache_macros.svh"

module miss_controller
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  lookup_t  lookup,
    input  cpu_req_t cur_req,
    input  logic     op_done,
    output logic     busy,
    output logic     resp_valid,
    output bus_op_e  bus_op,
    output logic     op_start,
    output logic     fill_en,
    output logic     touch_en,
    output logic     dirty_set,
    output logic     dirty_clear,
    output logic     store_hit_en
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        is_store;

    assign is_store = |cur_req.wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        op_start     = 1'b0;
        bus_op       = op_none;
        fill_en      = 1'b0;
        touch_en     = 1'b0;
        dirty_set    = 1'b0;
        dirty_clear  = 1'b0;
        store_hit_en = 1'b0;
        case (state)
            st_idle: begin
                if (req_valid) next_state = st_lookup;
            end
            st_lookup: begin
                if (lookup.hit) begin
                    touch_en     = 1'b1;
                    store_hit_en = is_store;
                    dirty_set    = is_store;
                    next_state   = st_respond;
                end else if (lookup.victim_dirty) begin
                    op_start   = 1'b1;
                    bus_op     = op_write_line;   // evict first
                    next_state = st_write_back;
                end else begin
                    op_start   = 1'b1;
                    bus_op     = op_read_line;
                    next_state = st_refill;
                end
            end
            st_write_back: begin
                if (op_done) begin
                    op_start   = 1'b1;
                    bus_op     = op_read_line;
                    next_state = st_refill;
                end
            end
            st_refill: begin
                if (op_done) begin
                    fill_en     = 1'b1;
                    dirty_set   = is_store;   // store bytes already merged in
                    dirty_clear = ~is_store;
                    next_state  = st_respond;
                end
            end
            st_respond: next_state = st_idle;
            default:    next_state = st_idle;
        endcase
    end

    assign busy       = (state != st_idle);
    assign resp_valid = (state == st_respond);

    // processor must wait for busy to drop
    a_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !busy)
        else $error("request sent while cache busy");

    a_done_unexpected: assert property (@(posedge clk) disable iff (rst)
        op_done |-> state inside {st_write_back, st_refill})
        else $error("burst finished with no burst pending");

endmodule

// File: logic/line_store.sv
`include "dcache_macros.svh"

module line_store
    import cache_pkg::*;
(
    input  logic                    clk,
    input  cpu_req_t                cur_req,
    input  lookup_t                 lookup,
    input  logic                    store_hit_en,
    input  logic                    beat_valid,
    input  logic [`DC_OFFSET_W-3:0] beat_index,
    input  logic [`DC_DATA_W-1:0]   beat_data,
    input  logic [`DC_OFFSET_W-3:0] wb_index,
    output logic [`DC_DATA_W-1:0]   wb_data,
    output cpu_resp_t               resp
);

    logic [`DC_DATA_W-1:0] data_arr [`DC_WAYS][`DC_SETS][`DC_WORDS];

    logic [`DC_INDEX_W-1:0]  idx;
    logic [`DC_OFFSET_W-3:0] word;
    logic [`DC_DATA_W-1:0]   byte_mask;
    logic [`DC_DATA_W-1:0]   hit_word;
    logic [`DC_DATA_W-1:0]   fill_word;

    assign idx  = cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign word = cur_req.addr[`DC_OFFSET_W-1:2];

    always_comb begin
        for (int b = 0; b < `DC_DATA_W/8; b++) begin
            byte_mask[b*8 +: 8] = {8{cur_req.wen[b]}};
        end
    end

    assign hit_word = data_arr[lookup.hit_way][idx][word];

    // mask is zero for a load, so only a store changes the beat
    assign fill_word = (beat_index == word) ?
                       (beat_data & ~byte_mask) | (cur_req.wdata & byte_mask) : beat_data;

    always_ff @(posedge clk) begin
        if (store_hit_en) begin
            data_arr[lookup.hit_way][idx][word] <=
                (hit_word & ~byte_mask) | (cur_req.wdata & byte_mask);
        end
        if (beat_valid) begin
            data_arr[lookup.victim_way][idx][beat_index] <= fill_word;
        end
    end

    // by the respond cycle the line is present, a refilled one included
    assign resp.rdata = hit_word;
    assign wb_data    = data_arr[lookup.victim_way][idx][wb_index];   // write-back source

endmodule

// File: logic/burst_port.sv
`include "dcache_macros.svh"

module burst_port
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_start,
    input  bus_op_e                 bus_op,
    input  cpu_req_t                cur_req,
    input  lookup_t                 lookup,
    input  logic [`DC_DATA_W-1:0]   wb_data,
    input  logic                    arready,
    input  burst_data_t             r,
    input  logic                    rvalid,
    input  logic                    awready,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    op_done,
    output logic                    beat_valid,
    output logic [`DC_OFFSET_W-3:0] beat_index,
    output logic [`DC_DATA_W-1:0]   beat_data,
    output logic [`DC_OFFSET_W-3:0] wb_index,
    output burst_addr_t             ar,
    output logic                    arvalid,
    output logic                    rready,
    output burst_addr_t             aw,
    output logic                    awvalid,
    output burst_data_t             w,
    output logic                    wvalid,
    output logic                    bready
);

    localparam int BEAT_W = `DC_OFFSET_W - 2;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DC_WORDS - 1);

    logic                   rd_active;
    logic                   wr_active;
    logic                   b_wait;
    logic [BEAT_W-1:0]      rcnt;
    logic [BEAT_W-1:0]      wcnt;
    logic [`DC_INDEX_W-1:0] idx;
    logic                   r_fire;
    logic                   w_fire;
    logic                   b_fire;

    assign idx = cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];

    // line addresses, offset cleared
    assign ar.addr = {cur_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W], idx, {`DC_OFFSET_W{1'b0}}};
    assign ar.len  = 8'(`DC_WORDS - 1);
    assign aw.addr = {lookup.victim_tag, idx, {`DC_OFFSET_W{1'b0}}};
    assign aw.len  = 8'(`DC_WORDS - 1);

    assign rready  = rd_active;
    assign wvalid  = wr_active;
    assign bready  = b_wait;
    assign w.data  = wb_data;
    assign w.last  = (wcnt == LAST_BEAT);

    assign r_fire = rvalid & rready;
    assign w_fire = wvalid & wready;
    assign b_fire = bvalid & bready;

    assign beat_valid = r_fire;
    assign beat_index = rcnt;
    assign beat_data  = r.data;
    assign wb_index   = wcnt;
    assign op_done    = (r_fire & r.last) | b_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid   <= 1'b0;
            awvalid   <= 1'b0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_wait    <= 1'b0;
            rcnt      <= '0;
            wcnt      <= '0;
        end else begin
            if (op_start && bus_op == op_read_line) arvalid <= 1'b1;
            else if (arvalid && arready) arvalid <= 1'b0;
            if (op_start && bus_op == op_write_line) awvalid <= 1'b1;
            else if (awvalid && awready) awvalid <= 1'b0;

            if (arvalid && arready) rd_active <= 1'b1;
            else if (r_fire && r.last) rd_active <= 1'b0;
            if (r_fire) rcnt <= r.last ? '0 : rcnt + 1'b1;

            // data beats only after the write address is taken
            if (awvalid && awready) wr_active <= 1'b1;
            else if (w_fire && w.last) wr_active <= 1'b0;
            if (w_fire) wcnt <= w.last ? '0 : wcnt + 1'b1;

            if (w_fire && w.last) b_wait <= 1'b1;
            else if (b_fire) b_wait <= 1'b0;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar dropped or changed before arready");

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw dropped or changed before awready");

endmodule

// File: logic/dcache_top.sv
`include "dcache_macros.svh"

module dcache_top
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // processor side
    input  logic        req_valid,
    input  cpu_req_t    req,
    output logic        busy,
    output logic        resp_valid,
    output cpu_resp_t   resp,
    // read address / data
    output logic        arvalid,
    output burst_addr_t ar,
    input  logic        arready,
    input  logic        rvalid,
    input  burst_data_t r,
    output logic        rready,
    // write address / data / response
    output logic        awvalid,
    output burst_addr_t aw,
    input  logic        awready,
    output logic        wvalid,
    output burst_data_t w,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    cpu_req_t                cur_req;
    lookup_t                 lookup;
    bus_op_e                 bus_op;
    logic                    op_start;
    logic                    op_done;
    logic                    fill_en;
    logic                    touch_en;
    logic                    dirty_set;
    logic                    dirty_clear;
    logic                    store_hit_en;
    logic                    beat_valid;
    logic [`DC_OFFSET_W-3:0] beat_index;
    logic [`DC_DATA_W-1:0]   beat_data;
    logic [`DC_OFFSET_W-3:0] wb_index;
    logic [`DC_DATA_W-1:0]   wb_data;

    tag_directory u_tag_directory (
        .clk, .rst, .req_valid, .req,
        .fill_en, .touch_en, .dirty_set, .dirty_clear,
        .cur_req, .lookup
    );

    miss_controller u_miss_controller (
        .clk, .rst, .req_valid, .lookup, .cur_req, .op_done,
        .busy, .resp_valid, .bus_op, .op_start,
        .fill_en, .touch_en, .dirty_set, .dirty_clear, .store_hit_en
    );

    line_store u_line_store (
        .clk, .cur_req, .lookup, .store_hit_en,
        .beat_valid, .beat_index, .beat_data, .wb_index,
        .wb_data, .resp
    );

    burst_port u_burst_port (
        .clk, .rst, .op_start, .bus_op, .cur_req, .lookup, .wb_data,
        .arready, .r, .rvalid, .awready, .wready, .bvalid,
        .op_done, .beat_valid, .beat_index, .beat_data, .wb_index,
        .ar, .arvalid, .rready, .aw, .awvalid, .w, .wvalid, .bready
    );

endmodule

// File: verification/mem_model.sv
`include "dcache_macros.svh"

module mem_model
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    input  burst_addr_t ar,
    output logic        arready,
    output logic        rvalid,
    output burst_data_t r,
    input  logic        rready,
    input  logic        awvalid,
    input  burst_addr_t aw,
    output logic        awready,
    input  logic        wvalid,
    input  burst_data_t w,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output int          read_bursts,
    output int          write_bursts,
    output burst_addr_t last_ar,
    output burst_addr_t last_aw
);

    localparam int MEM_WORDS = 4096;   // 16 KB window

    logic [`DC_DATA_W-1:0] mem [MEM_WORDS];
    integer      seed = 39680;
    logic        rd_on;
    logic        b_on;
    logic [11:0] rd_ptr;
    logic [11:0] wr_ptr;
    logic [7:0]  rd_beat;
    logic        ar_go;
    logic        r_go;
    logic        aw_go;
    logic        w_go;
    logic        b_go;
    burst_data_t w_seen;

    function automatic logic [31:0] fill_value(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a0f_c3e1;
    endfunction

    initial begin
        {arready, awready, wready, rvalid, bvalid} = '0;
        r = '0;
        {rd_on, b_on, ar_go, r_go, aw_go, w_go, b_go} = '0;
        {rd_ptr, wr_ptr, rd_beat} = '0;
        read_bursts  = 0;
        write_bursts = 0;
        last_ar      = '0;
        last_aw      = '0;
        w_seen       = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_value(32'(i) << 2);
    end

    // handshakes flagged here took place on the rising edge just passed
    always @(negedge clk) begin
        if (!rst) begin
            if (ar_go) begin
                read_bursts++;
                rd_on   = 1'b1;
                rd_ptr  = last_ar.addr[13:2];
                rd_beat = '0;
            end
            if (r_go) begin
                rvalid = 1'b0;
                rd_ptr++;
                rd_beat++;
                if (r.last) rd_on = 1'b0;
            end
            if (aw_go) begin
                write_bursts++;
                wr_ptr = last_aw.addr[13:2];
            end
            if (w_go) begin
                mem[wr_ptr] = w_seen.data;
                wr_ptr++;
                if (w_seen.last) b_on = 1'b1;
            end
            if (b_go) begin
                bvalid = 1'b0;
                b_on   = 1'b0;
            end
            arready = ($random(seed) & 3) != 0;   // stall about one cycle in four
            awready = ($random(seed) & 3) != 0;
            wready  = ($random(seed) & 3) != 0;
            if (rd_on && !rvalid && ($random(seed) & 3) != 0) begin
                rvalid = 1'b1;
                r.data = mem[rd_ptr];
                r.last = (rd_beat == last_ar.len);
            end
            if (b_on && !bvalid && ($random(seed) & 1) != 0)
                bvalid = 1'b1;
            // dut valids are registered, so these hold until the next edge
            ar_go = arvalid && arready;
            r_go  = rvalid && rready;
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            b_go  = bvalid && bready;
            if (ar_go) last_ar = ar;
            if (aw_go) last_aw = aw;
            w_seen = w;
        end
    end

endmodule

// File: verification/tb_dcache.sv
`include "dcache_macros.svh"

module tb_dcache
    import cache_pkg::*;
    import bus_pkg::*;
();

    localparam int NUM_TESTS  = 6;
    localparam int TEST_BOUND = 8000;   // time units per test
    localparam int RESP_LIMIT = 200;    // cycles per access

    logic        clk;
    logic        rst;
    logic        req_valid;
    cpu_req_t    req;
    logic        busy;
    logic        resp_valid;
    cpu_resp_t   resp;
    logic        arvalid;
    burst_addr_t ar;
    logic        arready;
    logic        rvalid;
    burst_data_t r;
    logic        rready;
    logic        awvalid;
    burst_addr_t aw;
    logic        awready;
    logic        wvalid;
    burst_data_t w;
    logic        wready;
    logic        bvalid;
    logic        bready;
    int          read_bursts;
    int          write_bursts;
    burst_addr_t last_ar;
    burst_addr_t last_aw;

    // reference model: program view of memory plus the cache directory
    logic [31:0]          view    [4096];
    logic [`DC_TAG_W-1:0] m_tag   [`DC_SETS][`DC_WAYS];
    logic                 m_valid [`DC_SETS][`DC_WAYS];
    logic                 m_dirty [`DC_SETS][`DC_WAYS];
    logic [2:0]           m_lru   [`DC_SETS];
    int                   errors;
    int                   tests_run;
    int                   tests_failed;

    dcache_top dut0 (.*);

    mem_model mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * TEST_BOUND);
        $display("watchdog expired before the tests completed");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] expected_init(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a0f_c3e1;
    endfunction

    function automatic void touch_lru(input int set, input logic [1:0] way);
        m_lru[set][0] = ~way[1];
        if (way[1])
            m_lru[set][2] = ~way[0];
        else
            m_lru[set][1] = ~way[0];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errors - err_before);
        end
    endtask

    // one processor request, predicted by the model and then checked
    task automatic access(input logic [31:0] addr, input logic [3:0] wen,
                          input logic [31:0] wdata);
        int                   set;
        logic [`DC_TAG_W-1:0] tag;
        logic [1:0]           way;
        logic                 hit;
        logic                 wb;
        logic [31:0]          wb_line;
        int                   rd0;
        int                   wr0;
        int                   lat;
        set = addr[7:5];
        tag = addr[31:8];
        hit = 1'b0;
        wb  = 1'b0;
        way = '0;
        for (int wy = 0; wy < `DC_WAYS; wy++) begin
            if (m_valid[set][wy] && m_tag[set][wy] == tag) begin
                hit = 1'b1;
                way = 2'(wy);
            end
        end
        if (hit) begin
            if (|wen) m_dirty[set][way] = 1'b1;
        end else begin
            way     = {m_lru[set][0], m_lru[set][0] ? m_lru[set][2] : m_lru[set][1]};
            wb      = m_valid[set][way] && m_dirty[set][way];
            wb_line = {m_tag[set][way], 3'(set), 5'b0};
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = |wen;
        end
        touch_lru(set, way);
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) view[addr[13:2]][b*8 +: 8] = wdata[b*8 +: 8];
        end

        while (busy) @(negedge clk);
        rd0 = read_bursts;
        wr0 = write_bursts;
        req_valid = 1'b1;
        req       = '{addr: addr, wen: wen, wdata: wdata};
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        check_value(busy, 1'b1, "busy after request");
        while (!resp_valid && lat < RESP_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        assert (resp_valid) else begin
            $display("no response to the request at %h within %0d cycles", addr, lat);
            errors++;
            return;
        end

        check_value(busy, 1'b1, "busy in response cycle");
        if (wen == 4'b0000) check_value(resp.rdata, view[addr[13:2]], "load data");
        if (hit) check_value(lat, 2, "hit latency");
        check_value(read_bursts - rd0, hit ? 0 : 1, "read burst count");
        check_value(write_bursts - wr0, wb ? 1 : 0, "write burst count");
        if (!hit) begin
            check_value(last_ar.addr, {addr[31:5], 5'b0}, "refill address");
            check_value(last_ar.len, 7, "refill length");
        end
        if (wb) begin
            check_value(last_aw.addr, wb_line, "write-back address");
            check_value(last_aw.len, 7, "write-back length");
            for (int i = 0; i < `DC_WORDS; i++)
                check_value(mem0.mem[wb_line[13:2] + i], view[wb_line[13:2] + i],
                            "write-back data");
        end
    endtask

    task automatic check_reset();
        int e0 = errors;
        check_value(busy, 1'b0, "busy after reset");
        check_value(resp_valid, 1'b0, "resp_valid after reset");
        check_value(arvalid, 1'b0, "arvalid after reset");
        check_value(awvalid, 1'b0, "awvalid after reset");
        check_value(wvalid, 1'b0, "wvalid after reset");
        end_test("reset", e0);
    endtask

    task automatic miss_then_hit();
        int e0 = errors;
        access(32'h0000_0124, 4'b0000, '0);
        access(32'h0000_0130, 4'b0000, '0);   // same line
        end_test("load miss/hit", e0);
    endtask

    task automatic store_hit_merge();
        int e0 = errors;
        access(32'h0000_0128, 4'b0110, 32'hdead_beef);
        access(32'h0000_0128, 4'b0000, '0);
        end_test("store hit", e0);
    endtask

    task automatic store_miss_allocate();
        int e0 = errors;
        access(32'h0000_0244, 4'b1001, 32'h1122_3344);
        access(32'h0000_0244, 4'b0000, '0);
        access(32'h0000_0248, 4'b0000, '0);
        end_test("store miss", e0);
    endtask

    task automatic dirty_eviction();
        int e0  = errors;
        int wr0 = write_bursts;
        for (int t = 1; t <= 4; t++)
            access((t << 8) | 32'h64, 4'b0011, 32'hc0de_0000 + t);
        access(32'h0000_0164, 4'b0000, '0);   // moves tag 1 off the victim path
        access(32'h0000_0564, 4'b0000, '0);   // fifth tag in set 3
        for (int t = 1; t <= 4; t++)
            access((t << 8) | 32'h64, 4'b0000, '0);
        assert (write_bursts > wr0) else begin
            $display("dirty eviction test saw no write-back burst");
            errors++;
        end
        end_test("dirty eviction", e0);
    endtask

    task automatic clean_eviction();
        int e0  = errors;
        int wr0 = write_bursts;
        for (int t = 1; t <= 5; t++)
            access((t << 8) | 32'h88, 4'b0000, '0);
        check_value(write_bursts - wr0, 0, "write bursts on clean eviction");
        end_test("clean eviction", e0);
    endtask

    initial begin
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 4096; i++)
            view[i] = expected_init(32'(i) << 2);
        for (int s = 0; s < `DC_SETS; s++) begin
            m_lru[s] = '0;
            for (int wy = 0; wy < `DC_WAYS; wy++) begin
                m_tag[s][wy]   = '0;
                m_valid[s][wy] = 1'b0;
                m_dirty[s][wy] = 1'b0;
            end
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_reset();
        miss_then_hit();
        store_hit_merge();
        store_miss_allocate();
        dirty_eviction();
        clean_eviction();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+logic
logic/cache_pkg.sv
logic/bus_pkg.sv
logic/tag_directory.sv
logic/miss_controller.sv
logic/line_store.sv
logic/burst_port.sv
logic/dcache_top.sv
verification/mem_model.sv
verification/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the data cache testbench with Verilator, runs it, then checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_dcache \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_dcache > sim.log 2>&1 \
    || { echo "build or simulation run did not complete"; exit 1; }
grep -qx '\*\* PASS \*\*' sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }
